// File: hw/playfieldPkg.sv
package playfieldPkg;

	// ------------------------------
	// Screen geometry
	// ------------------------------
	typedef logic [9:0]  coordT;   // Pixel column or row on screen
	typedef logic [20:0] worldT;   // Scroll offset into the level

	// Collision limits around the sprite, refreshed every frame
	typedef struct packed
	{
		coordT ceiling;     // Lowest free row above
		coordT floor;       // Highest free row below
		coordT wallLeft;    // Nearest blocked column on the left
		coordT wallRight;   // Nearest blocked column on the right
	} limitsT;

	// ------------------------------
	// Constants
	// ------------------------------

	// Sprite is 16x16, so it reaches 15 pixels past its top-left corner
	localparam coordT spriteSpan = 10'd15;

	localparam coordT scrollLine   = 10'd320;   // Column where the world starts to scroll
	localparam coordT scrollMargin = 10'd30;    // Look-ahead to the right wall

endpackage

// File: hw/motionPkg.sv
package motionPkg;

	// ------------------------------
	// Velocity types
	// ------------------------------
	typedef logic [5:0] speedT;   // Pixels per frame

	// Sign and magnitude on one axis
	typedef struct packed
	{
		logic  neg;   // Left on X, up on Y
		speedT mag;
	} axisVelT;

	typedef struct packed
	{
		axisVelT vel;
		logic    started;   // Set by the first right key
	} runT;

	// ------------------------------
	// Keyboard and jump constants
	// ------------------------------
	localparam logic [7:0] keyLeft  = 8'h04;   // A
	localparam logic [7:0] keyRight = 8'h07;   // D
	localparam logic [7:0] keyJump  = 8'h1A;   // W

	localparam logic [5:0] jumpLength     = 6'd63;   // Frames in one arc
	localparam speedT      jumpFall       = 6'd4;    // Gravity acting during the arc
	localparam logic [5:0] riseStepFrames = 6'd6;    // Rise drops by 1 this often

	// Vertical FSM
	typedef enum logic
	{
		freeFall,
		jumpRise
	} verticalModeT;

endpackage

// File: hw/runControl.sv
`timescale 1ns/100ps

module runControl import motionPkg::*;
#(
	parameter speedT runSpeed = 6'd2
)
(
	input  logic       Reset,       // Frame clock
	input  logic       frame_clk,   // Async reset, active high
	input  logic [7:0] keycode,
	output runT        run
);

	// ------------------------------
	// Horizontal velocity register
	// ------------------------------
	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
			run <= '0;   // Standing, play not started
		else
		begin
			case (keycode)
				keyLeft:
				begin
					run.vel.neg <= 1'b1;
					run.vel.mag <= runSpeed;
				end
				keyRight:
				begin
					run.vel.neg <= 1'b0;
					run.vel.mag <= runSpeed;
					run.started <= 1'b1;   // Sticky until reset
				end
				default:
				begin
					run.vel.neg <= 1'b0;   // Any other key stands still
					run.vel.mag <= '0;
				end
			endcase
		end
	end

	// Speed is all or nothing, the position clamps rely on it
	runSpeedA: assert property (@(posedge Reset) disable iff (frame_clk)
		run.vel.mag == '0 || run.vel.mag == runSpeed)
		else $error("run magnitude %0d is not 0 or runSpeed", run.vel.mag);

endmodule

// File: hw/jumpControl.sv
`timescale 1ns/100ps

module jumpControl import motionPkg::*;
#(
	parameter speedT fallSpeed = 6'd3,
	parameter speedT jumpRise  = 6'd9   // Hides the enum label, see motionPkg::jumpRise
)
(
	input  logic       Reset,       // Frame clock
	input  logic       frame_clk,   // Async reset
	input  logic [7:0] keycode,
	output axisVelT    fall
);

	verticalModeT mode, nextMode;
	logic [5:0]   jumpCnt, nextCnt;   // Frames left in the arc
	speedT        rise, nextRise;     // Upward push, decays over the arc
	axisVelT      nextFall;

	// ------------------------------
	// Next state
	// ------------------------------
	always_comb
	begin
		nextMode = mode;
		nextCnt  = jumpCnt;
		nextRise = rise;
		case (mode)
			freeFall:
				if (keycode == keyJump)   // Jump only from free fall
				begin
					nextMode = motionPkg::jumpRise;
					nextCnt  = jumpLength;
					nextRise = jumpRise;
				end
			default:   // In the arc, keys ignored
			begin
				nextCnt = jumpCnt - 6'd1;
				if ((nextCnt % riseStepFrames) == 6'd0 && rise != '0)
					nextRise = rise - 6'd1;
				if (nextCnt == 6'd0)
					nextMode = freeFall;   // Arc done
			end
		endcase
	end

	// Net vertical speed as sign and magnitude
	always_comb
	begin
		if (mode == freeFall && keycode != keyJump)
		begin
			nextFall.neg = 1'b0;   // Plain gravity
			nextFall.mag = fallSpeed;
		end
		else if (nextRise > jumpFall)
		begin
			nextFall.neg = 1'b1;   // Still going up
			nextFall.mag = nextRise - jumpFall;
		end
		else
		begin
			nextFall.neg = 1'b0;
			nextFall.mag = jumpFall - nextRise;
		end
	end

	// ------------------------------
	// State registers
	// ------------------------------
	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			mode    <= freeFall;
			jumpCnt <= '0;
			rise    <= '0;
			fall    <= '0;
		end
		else
		begin
			mode    <= nextMode;
			jumpCnt <= nextCnt;
			rise    <= nextRise;
			fall    <= nextFall;
		end
	end

	// Counter is parked at zero between arcs
	idleCntA: assert property (@(posedge Reset) disable iff (frame_clk)
		mode == freeFall |-> jumpCnt == '0);
	riseMaxA: assert property (@(posedge Reset) disable iff (frame_clk) rise <= jumpRise);

endmodule

// File: hw/positionUpdate.sv
`timescale 1ns/100ps

module positionUpdate import playfieldPkg::*, motionPkg::*;
#(
	parameter coordT startX = 10'd50,
	parameter coordT startY = 10'd300
)
(
	input  logic    Reset,       // Frame clock
	input  logic    frame_clk,   // Async reset
	input  runT     run,
	input  axisVelT fall,
	input  limitsT  limits,
	output coordT   posX,        // Sprite top-left corner
	output coordT   posY,
	output worldT   worldX       // Scroll offset
);

	// Edge sums one bit wider so nothing wraps
	logic [10:0] upReach;       // ceiling + m, Y-m below ceiling when Y is under this
	logic [10:0] downReach;     // Bottom edge after the move
	logic [10:0] rightReach;    // Right edge after the move
	logic [10:0] leftReach;     // wallLeft + m
	logic [10:0] scrollReach;   // Look-ahead edge for scrolling
	logic        walkX;         // Sprite moves itself, no scroll
	coordT       nextX, nextY;
	worldT       nextWorld;

	assign upReach     = 11'(limits.ceiling) + 11'(fall.mag);
	assign downReach   = 11'(posY) + 11'(fall.mag) + 11'(spriteSpan);
	assign rightReach  = 11'(posX) + 11'(run.vel.mag) + 11'(spriteSpan);
	assign leftReach   = 11'(limits.wallLeft) + 11'(run.vel.mag);
	assign scrollReach = 11'(posX) + 11'(run.vel.mag) + 11'(scrollMargin);
	assign walkX       = (posX < scrollLine) || run.vel.neg;

	// ------------------------------
	// Vertical move
	// ------------------------------
	always_comb
	begin
		if (fall.neg)
		begin
			if (11'(posY) < upReach)
				nextY = limits.ceiling + 10'd1;   // Head hits the ceiling
			else
				nextY = posY - 10'(fall.mag);
		end
		else if (downReach > 11'(limits.floor))
			nextY = limits.floor - 10'd1 - spriteSpan;   // Land on the floor
		else
			nextY = posY + 10'(fall.mag);
	end

	// ------------------------------
	// Horizontal move and scroll
	// ------------------------------
	always_comb
	begin
		nextX     = posX;
		nextWorld = worldX;
		if (walkX)
		begin
			if (!run.vel.neg)
			begin
				if (rightReach > 11'(limits.wallRight))
					nextX = limits.wallRight - 10'd1 - spriteSpan;
				else
					nextX = posX + 10'(run.vel.mag);
			end
			else if (11'(posX) < leftReach)
				nextX = limits.wallLeft + 10'd1;
			else
				nextX = posX - 10'(run.vel.mag);
		end
		else
		begin
			nextX = scrollLine;   // Pinned, the world moves instead
			if (run.vel.mag != '0 && scrollReach <= 11'(limits.wallRight))
				nextWorld = worldX + 21'd1;
		end
	end

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			posX   <= startX;
			posY   <= startY;
			worldX <= '0;
		end
		else if (run.started)   // Frozen until the first right key
		begin
			posX   <= nextX;
			posY   <= nextY;
			worldX <= nextWorld;
		end
	end

	// Overshoot past the scroll line is pulled back on the next frame
	scrollPinA: assert property (@(posedge Reset) disable iff (frame_clk)
		run.started && posX >= scrollLine && !run.vel.neg |=> posX == scrollLine);

endmodule

// File: hw/marioMotion.sv
`timescale 1ns/100ps

module marioMotion import playfieldPkg::*, motionPkg::*;
#(
	parameter speedT runSpeed  = 6'd2,
	parameter speedT fallSpeed = 6'd3,
	parameter speedT jumpRise  = 6'd9,   // Peak upward push of a jump
	parameter coordT startX    = 10'd50,
	parameter coordT startY    = 10'd300
)
(
	input  logic       Reset,       // Frame clock, one edge per frame
	input  logic       frame_clk,   // Async reset, active high
	input  logic [7:0] keycode,
	input  limitsT     limits,
	output coordT      posX,
	output coordT      posY,
	output worldT      worldX
);

	runT     run;    // Horizontal velocity and start latch
	axisVelT fall;   // Vertical velocity

	// ------------------------------
	// Velocity stage
	// ------------------------------
	runControl #(.runSpeed(runSpeed)) runControl_i
	(
		.Reset(Reset), .frame_clk(frame_clk), .keycode(keycode), .run(run)
	);

	jumpControl #(.fallSpeed(fallSpeed), .jumpRise(jumpRise)) jumpControl_i
	(
		.Reset(Reset), .frame_clk(frame_clk), .keycode(keycode), .fall(fall)
	);

	// Position stage, one frame behind the velocities
	positionUpdate #(.startX(startX), .startY(startY)) positionUpdate_i
	(
		.Reset(Reset), .frame_clk(frame_clk), .run(run), .fall(fall), .limits(limits),
		.posX(posX), .posY(posY), .worldX(worldX)
	);

endmodule

// File: verification/marioModel.svh
`ifndef MARIO_MODEL_SVH
`define MARIO_MODEL_SVH

// ------------------------------
// Game rules, one call per frame
// ------------------------------
localparam int refRunSpeed   = 2;
localparam int refFallSpeed  = 3;
localparam int refJumpRise   = 9;    // Push loaded at take-off
localparam int refJumpFall   = 4;    // Gravity inside the arc
localparam int refJumpFrames = 63;
localparam int refStepFrames = 6;    // Rise decays once per 6 frames
localparam int refSpan       = 15;   // Sprite reach past its corner
localparam int refScrollLine = 320;
localparam int refMargin     = 30;
localparam int refStartX     = 50;
localparam int refStartY     = 300;
localparam logic [7:0] refKeyLeft  = 8'h04;
localparam logic [7:0] refKeyRight = 8'h07;
localparam logic [7:0] refKeyJump  = 8'h1A;

int   mX, mY, mWorld;      // Expected outputs
logic mStarted;            // Play begins on first right key
logic mRunNeg;
int   mRunMag;
logic mJumping;            // Inside the jump arc
int   mCnt, mRise;
logic mFallNeg;
int   mFallMag;

task automatic resetModel();
	mX       = refStartX;
	mY       = refStartY;
	mWorld   = 0;
	mStarted = 1'b0;
	mRunNeg  = 1'b0;
	mRunMag  = 0;
	mJumping = 1'b0;
	mCnt     = 0;
	mRise    = 0;
	mFallNeg = 1'b0;
	mFallMag = 0;
endtask

// Net arc speed, up while rise beats gravity
task automatic setArcVelocity();
	if (mRise > refJumpFall)
	begin
		mFallNeg = 1'b1;
		mFallMag = mRise - refJumpFall;
	end
	else
	begin
		mFallNeg = 1'b0;
		mFallMag = refJumpFall - mRise;
	end
endtask

// One rising edge: position from old velocities, then new velocities
task automatic stepModel(input logic [7:0] key, input limitsT lim);
	int ceil, flr, wallL, wallR;
	int newX, newY, newWorld;
	ceil     = int'(lim.ceiling);
	flr      = int'(lim.floor);
	wallL    = int'(lim.wallLeft);
	wallR    = int'(lim.wallRight);
	newX     = mX;
	newY     = mY;
	newWorld = mWorld;
	if (mStarted)   // Nothing moves before play starts
	begin
		if (mFallNeg)
		begin
			if (mY - mFallMag < ceil)
				newY = ceil + 1;   // Bumped head
			else
				newY = mY - mFallMag;
		end
		else if (mY + mFallMag + refSpan > flr)
			newY = flr - 1 - refSpan;   // Landed
		else
			newY = mY + mFallMag;
		if (mX < refScrollLine || mRunNeg)
		begin
			if (!mRunNeg)
				newX = (mX + mRunMag + refSpan > wallR) ? wallR - 1 - refSpan : mX + mRunMag;
			else
				newX = (mX - mRunMag < wallL) ? wallL + 1 : mX - mRunMag;
		end
		else
		begin
			newX = refScrollLine;   // Pinned, world scrolls
			if (mRunMag != 0 && mX + mRunMag + refMargin <= wallR)
				newWorld = mWorld + 1;
		end
	end
	// Horizontal velocity
	if (key == refKeyLeft)
	begin
		mRunNeg = 1'b1;
		mRunMag = refRunSpeed;
	end
	else if (key == refKeyRight)
	begin
		mRunNeg  = 1'b0;
		mRunMag  = refRunSpeed;
		mStarted = 1'b1;
	end
	else
	begin
		mRunNeg = 1'b0;
		mRunMag = 0;
	end
	// Vertical velocity
	if (!mJumping)
	begin
		if (key == refKeyJump)
		begin
			mJumping = 1'b1;
			mCnt     = refJumpFrames;
			mRise    = refJumpRise;
			setArcVelocity();
		end
		else
		begin
			mFallNeg = 1'b0;
			mFallMag = refFallSpeed;
		end
	end
	else
	begin
		mCnt = mCnt - 1;   // Keys ignored mid-arc
		if (mCnt % refStepFrames == 0 && mRise != 0)
			mRise = mRise - 1;
		setArcVelocity();
		if (mCnt == 0)
			mJumping = 1'b0;
	end
	mX     = newX;
	mY     = newY;
	mWorld = newWorld;
endtask

`endif

// File: verification/marioMotionTb.sv
`timescale 1ns/100ps

module marioMotionTb import playfieldPkg::*;
();

	localparam int frameCount = 1500;
	localparam int idleFrames = 20;   // Frames without a right key

	logic        Reset;       // Frame clock
	logic        frame_clk;   // Reset
	logic [7:0]  keycode;
	limitsT      limits;
	coordT       posX, posY;
	worldT       worldX;
	int          seed;
	int          errors;
	int          frame;
	logic [31:0] r;
	logic [3:0]  pick;

	`include "marioModel.svh"

	marioMotion dut_i
	(
		.Reset(Reset), .frame_clk(frame_clk), .keycode(keycode), .limits(limits),
		.posX(posX), .posY(posY), .worldX(worldX)
	);

	always #4 Reset = ~Reset;   // 8 ns frame period

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic compareSignal(input string name, input int got, input int expected);
		if (got != expected)
		begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h at frame %0d", name, got, expected, frame);
		end
	endtask

	task automatic checkOutputs();
		compareSignal("posX", int'(posX), mX);
		compareSignal("posY", int'(posY), mY);
		compareSignal("worldX", int'(worldX), mWorld);
	endtask

	// Legal limits with the ceiling above the floor and the walls apart
	task automatic randomLimits();
		limits.floor     = 10'(300 + {$random(seed)} % 180);
		limits.ceiling   = limits.floor - 10'(40 + {$random(seed)} % 100);   // Often inside the arc
		limits.wallLeft  = 10'({$random(seed)} % 100);
		limits.wallRight = 10'(330 + {$random(seed)} % 310);   // Low end blocks scrolling
	endtask

	// Mostly right, some left and jump, rest random codes
	task automatic randomKey(input logic allowRight);
		r    = $random(seed);
		pick = r[3:0];
		if (pick < 4'd8)
			keycode = allowRight ? refKeyRight : 8'h00;
		else if (pick < 4'd11)
			keycode = refKeyLeft;
		else if (pick < 4'd13)
			keycode = refKeyJump;
		else
			keycode = r[11:4];
		if (!allowRight && keycode == refKeyRight)
			keycode = 8'h00;   // Keep play frozen
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial
	begin
		seed      = 53;
		errors    = 0;
		frame     = 0;
		Reset     = 1'b0;
		frame_clk = 1'b1;   // Held in reset
		keycode   = 8'h00;
		limits    = {10'd0, 10'd479, 10'd0, 10'd639};
		resetModel();
		repeat (4) @(posedge Reset);
		@(negedge Reset);
		frame_clk = 1'b0;
		for (frame = 0; frame < frameCount; frame++)
		begin
			checkOutputs();   // Result of the previous edge
			if (frame % 12 == 0)
				randomLimits();
			randomKey(frame >= idleFrames);
			stepModel(keycode, limits);
			@(negedge Reset);
		end
		checkOutputs();
		$display("marioMotionTb: %0d frames checked, %0d errors", frameCount, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#((frameCount + 4 + 100) * 8);
		$display("Watchdog timeout, frame loop did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: build.f
+incdir+verification
hw/playfieldPkg.sv
hw/motionPkg.sv
hw/runControl.sv
hw/jumpControl.sv
hw/positionUpdate.sv
hw/marioMotion.sv
verification/marioMotionTb.sv

// File: Makefile
SIM      ?= verilator
TOP      ?= marioMotionTb
FILELIST ?= build.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
VFLAGS   ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verification/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(SIM) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
